// File: rx_framer.f
+incdir+rtl
rtl/vita_rx_pkg.sv
rtl/setting_reg.sv
rtl/vita_fifo.sv
rtl/vita_rx_framer.sv
rtl/vita_rx_top.sv
verif/tb_vita_rx_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f rx_framer.f \
   --top-module tb_vita_rx_top \
   -o tb_vita_rx_top

sim_out=$(./obj_dir/tb_vita_rx_top) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^SIMULATION PASSED$"; then
   exit 0
fi
exit 1

// File: verif/tb_vita_rx_top.sv
`default_nettype none

`include "vita_rx_params.svh"

module tb_vita_rx_top;

   localparam int          NUM_TESTS      = 6;
   localparam int          TIMEOUT_CYCLES = 200;
   localparam logic [31:0] HDR_WORD       = 32'hA5C3_7E91;  // only 31:20 reach the header

   localparam logic [7:0] ADDR_CLEAR    = 8'(`VRX_BASE + `VRX_OFS_CLEAR);
   localparam logic [7:0] ADDR_HEADER   = 8'(`VRX_BASE + `VRX_OFS_HEADER);
   localparam logic [7:0] ADDR_STREAMID = 8'(`VRX_BASE + `VRX_OFS_STREAMID);
   localparam logic [7:0] ADDR_TRAILER  = 8'(`VRX_BASE + `VRX_OFS_TRAILER);
   localparam logic [7:0] ADDR_SPP      = 8'(`VRX_BASE + `VRX_OFS_SPP);
   localparam logic [7:0] ADDR_NUMCHAN  = 8'(`VRX_BASE + `VRX_OFS_NUMCHAN);

   logic                          clk;
   logic                          reset;
   vita_rx_pkg::set_bus_t         set_i;
   vita_rx_pkg::sample_word_t     sample_i;
   logic                          sample_valid_i;
   logic                          sample_ready_o;
   vita_rx_pkg::pkt_line_t        pkt_o;
   logic                          pkt_valid_o;
   logic                          pkt_ready_i;
   logic [`VRX_FIFO_DEPTH_LOG2:0] fifo_occupied_o;

   // stimulus table, one entry per test
   string       name_tab  [NUM_TESTS];
   int          nchan_tab [NUM_TESTS];
   int          spp_tab   [NUM_TESTS];
   int          nsamp_tab [NUM_TESTS];
   logic [31:0] sid_tab   [NUM_TESTS];
   logic [31:0] trl_tab   [NUM_TESTS];
   logic [31:0] flag_tab  [NUM_TESTS];  // nibble s holds the flags of sample s
   logic [63:0] time_tab  [NUM_TESTS];  // time of sample 0
   int          ready_tab [NUM_TESTS];  // 0 always ready, 1 random

   vita_rx_pkg::pkt_line_t exp_q [$];
   vita_rx_pkg::pkt_line_t got_q [$];

   int seed;
   int error_count;
   int pass_count;
   int fail_count;

   vita_rx_top i_dut
   (
      .clk             (clk),
      .reset           (reset),
      .set_i           (set_i),
      .sample_i        (sample_i),
      .sample_valid_i  (sample_valid_i),
      .sample_ready_o  (sample_ready_o),
      .pkt_o           (pkt_o),
      .pkt_valid_o     (pkt_valid_o),
      .pkt_ready_i     (pkt_ready_i),
      .fifo_occupied_o (fifo_occupied_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic void set_row(input int r, input string name, input int nchan,
                                   input int spp, input int nsamp, input logic [31:0] sid,
                                   input logic [31:0] trl, input logic [31:0] flags,
                                   input logic [63:0] t0, input int rdy);
      name_tab[r]  = name;
      nchan_tab[r] = nchan;
      spp_tab[r]   = spp;
      nsamp_tab[r] = nsamp;
      sid_tab[r]   = sid;
      trl_tab[r]   = trl;
      flag_tab[r]  = flags;
      time_tab[r]  = t0;
      ready_tab[r] = rdy;
   endfunction

   function automatic void fill_table();
      //      name            chan spp nsmp stream id      trailer        flags
      set_row(0, "single_chan",  1, 4, 4, 32'h1000_0001, 32'hF000_0001, 32'h0,
              64'h0000_0012_0000_0100, 0);
      set_row(1, "three_chan",   3, 2, 2, 32'h1000_0002, 32'hF000_0002, 32'h0,
              64'h0000_0020_0000_0F00, 0);
      set_row(2, "pkt_count",    2, 2, 6, 32'h1000_0003, 32'hF000_0003, 32'h0,
              64'h0000_0031_8000_0000, 0);
      set_row(3, "err_first",    2, 3, 4, 32'h1000_0004, 32'hF000_0004, 32'h0000_0008,
              64'h0000_0040_0000_0044, 0);
      set_row(4, "flag_mid",     2, 4, 6, 32'h1000_0005, 32'hF000_0005, 32'h0000_0020,
              64'h0000_0055_0000_1234, 0);
      set_row(5, "random_ready", 4, 3, 6, 32'h1000_0006, 32'hF000_0006, 32'h0,
              64'h0000_0066_FFFF_FF00, 1);
   endfunction

   function automatic logic [3:0] flags_of(input int r, input int s);
      return flag_tab[r][s*4 +: 4];
   endfunction

   // time steps both halves so seconds and tics are told apart
   function automatic logic [63:0] sample_time(input int r, input int s);
      return time_tab[r] + 64'(s) * 64'h0000_0001_0000_0040;
   endfunction

   function automatic logic [31:0] chan_value(input int r, input int s, input int c);
      return {4'hC, 4'(r), 8'(s), 8'(c), 8'h5A};
   endfunction

   function automatic vita_rx_pkg::sample_word_t make_sample(input int r, input int s);
      vita_rx_pkg::sample_word_t sw;
      sw.flags     = flags_of(r, s);
      sw.vita_time = sample_time(r, s);
      for (int c = 0; c < `VRX_MAXCHAN; c++)
      begin
         sw.chan[c] = chan_value(r, s, c);  // unused channels must never show up
      end
      return sw;
   endfunction

   function automatic vita_rx_pkg::pkt_line_t make_line(input logic eof, input logic sof,
                                                        input logic [31:0] data);
      vita_rx_pkg::pkt_line_t ln;
      ln.eof  = eof;
      ln.sof  = sof;
      ln.data = data;
      return ln;
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      set_i.stb  = 1'b1;
      set_i.addr = addr;
      set_i.data = data;
      @(posedge clk);
      #1;
      set_i = '0;
   endtask

   task automatic apply_settings(input int r);
      write_setting(ADDR_NUMCHAN, 32'(nchan_tab[r]));
      write_setting(ADDR_SPP, 32'(spp_tab[r]));
      write_setting(ADDR_HEADER, HDR_WORD);
      write_setting(ADDR_TRAILER, trl_tab[r]);
      write_setting(ADDR_STREAMID, sid_tab[r]);  // packet count back to zero
   endtask

   // reference packet model built from the framing rules
   task automatic build_expected(input int r);
      int          s;
      int          k;
      logic [3:0]  f;
      logic [3:0]  count;
      logic        done;
      logic [63:0] t;
      exp_q.delete();
      s     = 0;
      count = 4'd0;
      while (s < nsamp_tab[r])
      begin
         f = flags_of(r, s);
         t = sample_time(r, s);
         exp_q.push_back(make_line(1'b0, 1'b1,
                                   {HDR_WORD[31:20], count, 16'(spp_tab[r] + 6)}));
         exp_q.push_back(make_line(1'b0, 1'b0, sid_tab[r]));
         exp_q.push_back(make_line(1'b0, 1'b0, t[63:32]));
         exp_q.push_back(make_line(1'b0, 1'b0, 32'd0));
         exp_q.push_back(make_line(1'b0, 1'b0, t[31:0]));
         if (f[3:1] != 3'd0)
         begin
            exp_q.push_back(make_line(1'b0, 1'b0, {28'd0, f}));
            exp_q.push_back(make_line(1'b1, 1'b1, trl_tab[r]));  // count stays
            s = s + 1;
         end
         else
         begin
            k    = s;
            done = 1'b0;
            while (!done)
            begin
               for (int c = 0; c < nchan_tab[r]; c++)
               begin
                  exp_q.push_back(make_line(1'b0, 1'b0, chan_value(r, k, c)));
               end
               if ((k - s + 1) == spp_tab[r] || flags_of(r, k) != 4'd0 ||
                   (k + 1) >= nsamp_tab[r])
                  done = 1'b1;
               k = k + 1;
            end
            exp_q.push_back(make_line(1'b1, 1'b0, trl_tab[r]));
            count = count + 4'd1;
            s     = k;
         end
      end
   endtask

   task automatic push_samples(input int r, input int n);
      int i;
      int stall;
      i     = 0;
      stall = 0;
      while (i < n && stall < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         #1;
         sample_i       = make_sample(r, i);
         sample_valid_i = 1'b1;
         @(negedge clk);
         if (sample_ready_o)
         begin
            i     = i + 1;  // taken on the coming edge
            stall = 0;
         end
         else
            stall = stall + 1;
      end
      @(posedge clk);
      #1;
      sample_valid_i = 1'b0;
      if (i < n)
      begin
         $display("test %s: sample input never became ready, %0d of %0d samples sent",
                  name_tab[r], i, n);
         error_count = error_count + 1;
      end
   endtask

   task automatic collect_lines(input int r, input int n);
      int idle;
      int rnd;
      idle = 0;
      got_q.delete();
      while (got_q.size() < n && idle < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         #1;
         if (ready_tab[r] == 1)
         begin
            rnd         = $random(seed);
            pkt_ready_i = rnd[0];
         end
         else
            pkt_ready_i = 1'b1;
         @(negedge clk);
         if (pkt_valid_o && pkt_ready_i)
         begin
            got_q.push_back(pkt_o);
            idle = 0;
         end
         else
            idle = idle + 1;
      end
      @(posedge clk);
      #1;
      pkt_ready_i = 1'b0;
      if (got_q.size() < n)
      begin
         $display("test %s: timed out waiting for packet lines, got %0d of %0d",
                  name_tab[r], got_q.size(), n);
         error_count = error_count + 1;
      end
   endtask

   task automatic compare_lines(input int r);
      for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
      begin
         if (got_q[i] !== exp_q[i])
         begin
            $display("** Error [%s] line %0d: expected %h, actual %h",
                     name_tab[r], i, exp_q[i], got_q[i]);
            error_count = error_count + 1;
         end
      end
      if (pkt_valid_o)
      begin
         $display("test %s: output still valid after the last expected line", name_tab[r]);
         error_count = error_count + 1;
      end
   endtask

   task automatic report_result(input string name, input int errs_before);
      if (error_count == errs_before)
      begin
         pass_count = pass_count + 1;
         $display("PASS  %s", name);
      end
      else
      begin
         fail_count = fail_count + 1;
         $display("FAIL  %s  (%0d errors)", name, error_count - errs_before);
      end
   endtask

   task automatic run_test(input int r);
      int errs_before;
      errs_before = error_count;
      apply_settings(r);
      build_expected(r);
      fork
         push_samples(r, nsamp_tab[r]);
         collect_lines(r, exp_q.size());
      join
      compare_lines(r);
      report_result(name_tab[r], errs_before);
   endtask

   // one packet parked in the output FIFO, then the clear register empties it
   task automatic check_clear();
      int errs_before;
      int waited;
      errs_before = error_count;
      pkt_ready_i = 1'b0;
      write_setting(ADDR_NUMCHAN, 32'd1);
      write_setting(ADDR_SPP, 32'd1);
      write_setting(ADDR_STREAMID, 32'h0000_C1EA);
      push_samples(0, 1);
      waited = 0;
      while (fifo_occupied_o != 7 && waited < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         waited = waited + 1;
      end
      if (fifo_occupied_o != 7)
      begin
         $display("test fifo_clear: pending packet never filled the output FIFO");
         error_count = error_count + 1;
      end
      write_setting(ADDR_CLEAR, 32'd0);
      waited = 0;
      while (fifo_occupied_o != 0 && waited < 4)
      begin
         @(negedge clk);
         waited = waited + 1;
      end
      if (fifo_occupied_o != 0)
      begin
         $display("** Error [fifo_clear] occupancy: expected 0, actual %0d", fifo_occupied_o);
         error_count = error_count + 1;
      end
      report_result("fifo_clear", errs_before);
   endtask

   initial
   begin
      seed           = 32;
      error_count    = 0;
      pass_count     = 0;
      fail_count     = 0;
      reset          = 1'b1;
      set_i          = '0;
      sample_i       = '0;
      sample_valid_i = 1'b0;
      pkt_ready_i    = 1'b0;
      fill_table();

      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      if (pkt_valid_o !== 1'b0 || fifo_occupied_o !== '0 || sample_ready_o !== 1'b1)
      begin
         $display("DUT not idle and empty after reset");
         error_count = error_count + 1;
      end

      for (int r = 0; r < NUM_TESTS; r++)
      begin
         run_test(r);
      end
      check_clear();

      $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
               error_count);
      if (fail_count == 0 && error_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/vita_rx_top.sv
`default_nettype none

`include "vita_rx_params.svh"

module vita_rx_top
(
   input  wire                             clk,
   input  wire                             reset,
   input  wire vita_rx_pkg::set_bus_t      set_i,
   input  wire vita_rx_pkg::sample_word_t  sample_i,
   input  wire                             sample_valid_i,
   output logic                            sample_ready_o,
   output vita_rx_pkg::pkt_line_t          pkt_o,
   output logic                            pkt_valid_o,
   input  wire                             pkt_ready_i,
   output logic [`VRX_FIFO_DEPTH_LOG2:0]   fifo_occupied_o
);

   // between the sample FIFO and the framer
   vita_rx_pkg::sample_word_t sample_q;
   logic                      sample_q_valid;
   logic                      sample_q_ready;

   // absorbs controller bursts while the framer sends fixed lines
   vita_fifo #(.payload_t(vita_rx_pkg::sample_word_t), .DEPTH_LOG2(`VRX_FIFO_DEPTH_LOG2))
   i_sample_fifo
   (
      .clk        (clk),
      .reset      (reset),
      .clear_i    (1'b0),       // the clear register only reaches the packet side
      .data_i     (sample_i),
      .valid_i    (sample_valid_i),
      .ready_o    (sample_ready_o),
      .data_o     (sample_q),
      .valid_o    (sample_q_valid),
      .ready_i    (sample_q_ready),
      .occupied_o ()
   );

   vita_rx_framer i_framer
   (
      .clk             (clk),
      .reset           (reset),
      .set_i           (set_i),
      .sample_i        (sample_q),
      .sample_valid_i  (sample_q_valid),
      .sample_ready_o  (sample_q_ready),
      .pkt_o           (pkt_o),
      .pkt_valid_o     (pkt_valid_o),
      .pkt_ready_i     (pkt_ready_i),
      .fifo_occupied_o (fifo_occupied_o)
   );

endmodule

`default_nettype wire

// File: rtl/vita_rx_framer.sv
`default_nettype none

`include "vita_rx_params.svh"

module vita_rx_framer
(
   input  wire                             clk,
   input  wire                             reset,
   input  wire vita_rx_pkg::set_bus_t      set_i,
   input  wire vita_rx_pkg::sample_word_t  sample_i,
   input  wire                             sample_valid_i,
   output logic                            sample_ready_o,
   output vita_rx_pkg::pkt_line_t          pkt_o,
   output logic                            pkt_valid_o,
   input  wire                             pkt_ready_i,
   output logic [`VRX_FIFO_DEPTH_LOG2:0]   fifo_occupied_o
);

   localparam int CH_W = $clog2(`VRX_MAXCHAN);

   logic [31:0]   hdr_set;
   logic [31:0]   streamid_set;
   logic [31:0]   trailer_set;
   logic [31:0]   spp_set;
   logic [31:0]   numchan_set;
   logic          clear_fifo;
   logic          clear_pkt_count;
   logic [15:0]   samples_per_packet;
   logic [15:0]   pkt_len;
   logic [CH_W:0] numchan;

   vita_rx_pkg::framer_state_t state;
   logic [CH_W-1:0]            phase;       // channel being written this cycle
   logic [15:0]                sample_ctr;  // counts from 1 within a packet
   logic [3:0]                 pkt_count;
   logic [31:0]                chan_word;
   logic                       last_chan;
   logic                       start_err;
   logic                       pkt_fifo_ready;
   logic                       req_write;
   vita_rx_pkg::pkt_line_t     line;

   setting_reg #(.my_addr(8'(`VRX_BASE + `VRX_OFS_CLEAR))) i_sr_clear
   (
      .clk       (clk),
      .reset     (reset),
      .set_i     (set_i),
      .out_o     (),
      .changed_o (clear_fifo)
   );

   setting_reg #(.my_addr(8'(`VRX_BASE + `VRX_OFS_HEADER))) i_sr_header
   (
      .clk       (clk),
      .reset     (reset),
      .set_i     (set_i),
      .out_o     (hdr_set),
      .changed_o ()
   );

   setting_reg #(.my_addr(8'(`VRX_BASE + `VRX_OFS_STREAMID))) i_sr_streamid
   (
      .clk       (clk),
      .reset     (reset),
      .set_i     (set_i),
      .out_o     (streamid_set),
      .changed_o (clear_pkt_count)
   );

   setting_reg #(.my_addr(8'(`VRX_BASE + `VRX_OFS_TRAILER))) i_sr_trailer
   (
      .clk       (clk),
      .reset     (reset),
      .set_i     (set_i),
      .out_o     (trailer_set),
      .changed_o ()
   );

   setting_reg #(.my_addr(8'(`VRX_BASE + `VRX_OFS_SPP))) i_sr_spp
   (
      .clk       (clk),
      .reset     (reset),
      .set_i     (set_i),
      .out_o     (spp_set),
      .changed_o ()
   );

   setting_reg #(.my_addr(8'(`VRX_BASE + `VRX_OFS_NUMCHAN)), .at_reset(32'd1)) i_sr_numchan
   (
      .clk       (clk),
      .reset     (reset),
      .set_i     (set_i),
      .out_o     (numchan_set),
      .changed_o ()
   );

   assign samples_per_packet = spp_set[15:0];
   assign pkt_len            = samples_per_packet + 16'd6;  // six fixed lines
   assign numchan            = numchan_set[CH_W:0];

   assign chan_word = sample_i.chan[phase];
   assign last_chan = ({1'b0, phase} == numchan - 1'b1);
   assign start_err = |sample_i.flags[3:1];  // cmd done alone is not an error

   // restarts on a stream id write
   always_ff @(posedge clk)
   begin
      if (reset || clear_pkt_count)
      begin
         pkt_count <= 4'd0;
      end
      else if (state == vita_rx_pkg::vita_trailer && pkt_fifo_ready)
      begin
         pkt_count <= pkt_count + 4'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= vita_rx_pkg::vita_idle;
         sample_ctr <= 16'd0;
         phase      <= '0;
      end
      else if (state == vita_rx_pkg::vita_idle)
      begin
         sample_ctr <= 16'd1;
         phase      <= '0;
         if (sample_valid_i)
         begin
            if (start_err)
               state <= vita_rx_pkg::vita_err_header;
            else
               state <= vita_rx_pkg::vita_header;
         end
      end
      else if (pkt_fifo_ready)  // full output FIFO freezes everything
      begin
         case (state)
            vita_rx_pkg::vita_payload:
            begin
               if (sample_valid_i)
               begin
                  if (last_chan)
                  begin
                     phase      <= '0;
                     sample_ctr <= sample_ctr + 16'd1;
                     // any flag ends the packet after this sample
                     if (sample_ctr == samples_per_packet || |sample_i.flags)
                        state <= vita_rx_pkg::vita_trailer;
                  end
                  else
                  begin
                     phase <= phase + 1'b1;
                  end
               end
            end
            vita_rx_pkg::vita_trailer, vita_rx_pkg::vita_err_trailer:
               state <= vita_rx_pkg::vita_idle;
            default:
               state <= vita_rx_pkg::framer_state_t'(state + 4'd1);  // walk the fixed lines
         endcase
      end
   end

   // payload lines wait for a sample, fixed lines always go
   always_comb
   begin
      case (state)
         vita_rx_pkg::vita_idle:    req_write = 1'b0;
         vita_rx_pkg::vita_payload: req_write = sample_valid_i;
         default:                   req_write = 1'b1;
      endcase
   end

   always_comb
   begin
      line = '0;
      case (state)
         vita_rx_pkg::vita_header, vita_rx_pkg::vita_err_header:
         begin
            line.sof  = 1'b1;
            line.data = {hdr_set[31:20], pkt_count, pkt_len};
         end
         vita_rx_pkg::vita_streamid, vita_rx_pkg::vita_err_streamid:
            line.data = streamid_set;
         vita_rx_pkg::vita_secs, vita_rx_pkg::vita_err_secs:
            line.data = sample_i.vita_time[63:32];
         vita_rx_pkg::vita_tics2, vita_rx_pkg::vita_err_tics2:
            line.data = sample_i.vita_time[31:0];
         vita_rx_pkg::vita_payload:
            line.data = chan_word;
         vita_rx_pkg::vita_err_payload:
            line.data = {28'd0, sample_i.flags};
         vita_rx_pkg::vita_trailer:
         begin
            line.eof  = 1'b1;
            line.data = trailer_set;
         end
         vita_rx_pkg::vita_err_trailer:
         begin
            line.sof  = 1'b1;  // error packets are flagged with sof on the trailer
            line.eof  = 1'b1;
            line.data = trailer_set;
         end
         default:
            line = '0;  // idle and tics lines carry zero
      endcase
   end

   // pop on the last channel line, or once the error packet is out
   assign sample_ready_o = pkt_fifo_ready &&
                           ((state == vita_rx_pkg::vita_payload && last_chan) ||
                            state == vita_rx_pkg::vita_err_trailer);

   vita_fifo #(.payload_t(vita_rx_pkg::pkt_line_t), .DEPTH_LOG2(`VRX_FIFO_DEPTH_LOG2)) i_pkt_fifo
   (
      .clk        (clk),
      .reset      (reset),
      .clear_i    (clear_fifo),
      .data_i     (line),
      .valid_i    (req_write),
      .ready_o    (pkt_fifo_ready),
      .data_o     (pkt_o),
      .valid_o    (pkt_valid_o),
      .ready_i    (pkt_ready_i),
      .occupied_o (fifo_occupied_o)
   );

   // channel count register bounds the payload phase
   a_phase_in_range: assert property (@(posedge clk) disable iff (reset)
      (state == vita_rx_pkg::vita_payload) |-> ({1'b0, phase} < numchan))
      else $error("vita_rx_framer: phase %0d not below channel count %0d", phase, numchan);

   a_state_legal: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(state) && (state != 4'd8))
      else $error("vita_rx_framer: undefined state code");

endmodule

`default_nettype wire

// File: rtl/vita_fifo.sv
`default_nettype none

module vita_fifo
#(
   parameter type payload_t  = logic [31:0],
   parameter int  DEPTH_LOG2 = 4
)
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   clear_i,
   input  wire payload_t         data_i,
   input  wire                   valid_i,
   output logic                  ready_o,
   output payload_t              data_o,
   output logic                  valid_o,
   input  wire                   ready_i,
   output logic [DEPTH_LOG2:0]   occupied_o
);

   localparam int DEPTH = 1 << DEPTH_LOG2;
   localparam logic [DEPTH_LOG2:0] FULL_COUNT = DEPTH[DEPTH_LOG2:0];

   payload_t              mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  do_push;
   logic                  do_pop;

   assign ready_o    = (count != FULL_COUNT);
   assign valid_o    = (count != '0);
   assign data_o     = mem[rd_ptr];   // head of queue, read without a register
   assign occupied_o = count;

   assign do_push = valid_i && ready_o;
   assign do_pop  = valid_o && ready_i;

   // storage only, pointers decide what is live
   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   // a full queue has its write pointer lapped exactly onto the read pointer
   a_no_overflow: assert property (@(posedge clk) disable iff (reset || clear_i)
      (count == FULL_COUNT) |-> (wr_ptr == rd_ptr))
      else $error("vita_fifo: pointers apart while full");

   a_count_bound: assert property (@(posedge clk) disable iff (reset)
      occupied_o <= FULL_COUNT)
      else $error("vita_fifo: occupancy %0d above depth", occupied_o);

endmodule

`default_nettype wire

// File: rtl/setting_reg.sv
`default_nettype none

module setting_reg
#(
   parameter logic [7:0]  my_addr  = 8'd0,
   parameter logic [31:0] at_reset = 32'd0
)
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire vita_rx_pkg::set_bus_t set_i,
   output logic [31:0]           out_o,
   output logic                  changed_o
);

   logic hit;

   assign hit = set_i.stb && (set_i.addr == my_addr);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_o     <= at_reset;
         changed_o <= 1'b0;
      end
      else
      begin
         if (hit)
         begin
            out_o <= set_i.data;
         end
         changed_o <= hit;  // high the cycle after the write lands
      end
   end

endmodule

`default_nettype wire

// File: rtl/vita_rx_pkg.sv
`default_nettype none

`include "vita_rx_params.svh"

package vita_rx_pkg;

   // one timestamped sample from the receive controller
   typedef struct packed
   {
      logic [3:0]                    flags;      // overrun, broken chain, late cmd, cmd done
      logic [63:0]                   vita_time;  // seconds in 63:32, tics in 31:0
      logic [`VRX_MAXCHAN-1:0][31:0] chan;       // chan[0] sits in the low bits
   } sample_word_t;

   // one packet line toward the buffer pool
   typedef struct packed
   {
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } pkt_line_t;

   // settings bus write, single cycle
   typedef struct packed
   {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // error states are the normal ones with bit 3 set, code 8 is never used
   typedef enum logic [3:0]
   {
      vita_idle         = 4'd0,
      vita_header       = 4'd1,
      vita_streamid     = 4'd2,
      vita_secs         = 4'd3,
      vita_tics         = 4'd4,
      vita_tics2        = 4'd5,
      vita_payload      = 4'd6,
      vita_trailer      = 4'd7,
      vita_err_header   = 4'd9,
      vita_err_streamid = 4'd10,
      vita_err_secs     = 4'd11,
      vita_err_tics     = 4'd12,
      vita_err_tics2    = 4'd13,
      vita_err_payload  = 4'd14,
      vita_err_trailer  = 4'd15
   } framer_state_t;

endpackage

`default_nettype wire

// File: rtl/vita_rx_params.svh
`ifndef VITA_RX_PARAMS_SVH
`define VITA_RX_PARAMS_SVH

// base address of the framer settings block on the settings bus
`define VRX_BASE            0

// register offsets, each one 32-bit word
`define VRX_OFS_CLEAR       3   // any write empties the output FIFO
`define VRX_OFS_HEADER      4   // bits 31:20 go into the header line
`define VRX_OFS_STREAMID    5   // writing it also restarts the packet count
`define VRX_OFS_TRAILER     6
`define VRX_OFS_SPP         7   // samples per packet, low 16 bits used
`define VRX_OFS_NUMCHAN     8   // channels per sample, 1 to VRX_MAXCHAN

// widest sample word the framer accepts
`define VRX_MAXCHAN         4

// both FIFOs hold 2**4 = 16 entries
`define VRX_FIFO_DEPTH_LOG2 4

`endif
